// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - rtl/cpu_pkg.sv
  - rtl/op_decoder.sv
  - rtl/execute_unit.sv
  - rtl/result_unit.sv
  - rtl/cpu_core.sv
  - target: test
    files:
      - dv/cpu_core_tb.sv

// ==== cpu_core.f ====
rtl/cpu_pkg.sv
rtl/op_decoder.sv
rtl/execute_unit.sv
rtl/result_unit.sv
rtl/cpu_core.sv
dv/cpu_core_tb.sv

// ==== dv/cpu_core_tb.sv ====
module cpu_core_tb import cpu_pkg::*; ();

        timeunit 1ns;
        timeprecision 1ps;

        typedef struct packed {
                byte_t   opcode;
                byte_t   operand;
                byte_t   a;
                byte_t   x;
                byte_t   y;
                byte_t   sp;
                status_t st;
                logic    ill;
                logic    chain;                 // Next entry strobed on the very next cycle
        } entry_t;

        logic    clk;
        logic    reset;
        logic    instr_valid;
        opcode_e opcode;
        byte_t   operand;
        byte_t   reg_a;
        byte_t   reg_x;
        byte_t   reg_y;
        byte_t   reg_sp;
        status_t status;
        logic    retire;
        logic    illegal;

        entry_t  table_q[$];
        int      pending[$];                    // Entries strobed but not yet retired
        int      issue_idx;
        int      idx;
        int      cycle_count;
        int      error_count;
        logic    last_chain;

        cpu_core #(
                .SP_RESET (8'hFD)
        ) uut (
                .clk         (clk),
                .reset       (reset),
                .instr_valid (instr_valid),
                .opcode      (opcode),
                .operand     (operand),
                .reg_a       (reg_a),
                .reg_x       (reg_x),
                .reg_y       (reg_y),
                .reg_sp      (reg_sp),
                .status      (status),
                .retire      (retire),
                .illegal     (illegal)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        task automatic abort_run();
                error_count++;
                $display("RESULT: FAIL");
                $fatal(1, "Simulation stopped on the first error");
        endtask

        task automatic check_reg(input byte_t got, input byte_t exp, input string what);
                if (got !== exp) begin
                        $display("FAILED at %0d ns: %s is %02h, expected %02h",
                                 $time, what, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_status(input status_t got, input status_t exp, input string what);
                if (got !== exp) begin
                        $display("FAILED at %0d ns: %s status nvdizc is %06b, expected %06b",
                                 $time, what, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_illegal(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        $display("FAILED at %0d ns: %s illegal is %b, expected %b",
                                 $time, what, got, exp);
                        abort_run();
                end
        endtask

        function automatic void add_entry(byte_t op, byte_t opd, byte_t a, byte_t x, byte_t y,
                                          byte_t sp, logic [5:0] st, logic ill, logic chain);
                entry_t e;
                e.opcode  = op;
                e.operand = opd;
                e.a       = a;
                e.x       = x;
                e.y       = y;
                e.sp      = sp;
                e.st      = status_t'(st);
                e.ill     = ill;
                e.chain   = chain;
                table_q.push_back(e);
        endfunction

        // Each row holds opcode, operand, expected A, X, Y, SP, flags nvdizc, illegal, chain
        task automatic build_table();
                add_entry(OP_LDA_IMM, 8'h80, 8'h80, 8'h00, 8'h00, 8'hFD, 6'b100100, 0, 0);
                add_entry(OP_LDX_IMM, 8'h00, 8'h80, 8'h00, 8'h00, 8'hFD, 6'b000110, 0, 0);
                add_entry(OP_LDY_IMM, 8'h7F, 8'h80, 8'h00, 8'h7F, 8'hFD, 6'b000100, 0, 0);
                add_entry(OP_TAX,     8'h00, 8'h80, 8'h80, 8'h7F, 8'hFD, 6'b100100, 0, 0);
                add_entry(OP_TAY,     8'h00, 8'h80, 8'h80, 8'h80, 8'hFD, 6'b100100, 0, 0);
                add_entry(OP_LDX_IMM, 8'hFF, 8'h80, 8'hFF, 8'h80, 8'hFD, 6'b100100, 0, 0);
                add_entry(OP_CMP_IMM, 8'h80, 8'h80, 8'hFF, 8'h80, 8'hFD, 6'b000111, 0, 0);
                add_entry(OP_TXS,     8'h00, 8'h80, 8'hFF, 8'h80, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_LDX_IMM, 8'h00, 8'h80, 8'h00, 8'h80, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_TSX,     8'h00, 8'h80, 8'hFF, 8'h80, 8'hFF, 6'b100101, 0, 0);
                add_entry(OP_TXA,     8'h00, 8'hFF, 8'hFF, 8'h80, 8'hFF, 6'b100101, 0, 0);
                add_entry(OP_LDY_IMM, 8'h00, 8'hFF, 8'hFF, 8'h00, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_TYA,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_CLC,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000110, 0, 0);
                add_entry(OP_LDA_IMM, 8'h7F, 8'h7F, 8'hFF, 8'h00, 8'hFF, 6'b000100, 0, 0);
                add_entry(OP_ADC_IMM, 8'h01, 8'h80, 8'hFF, 8'h00, 8'hFF, 6'b110100, 0, 0);
                add_entry(OP_ADC_IMM, 8'h80, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b010111, 0, 0);
                add_entry(OP_CLV,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_LDA_IMM, 8'h50, 8'h50, 8'hFF, 8'h00, 8'hFF, 6'b000101, 0, 0);
                add_entry(OP_SBC_IMM, 8'h10, 8'h40, 8'hFF, 8'h00, 8'hFF, 6'b000101, 0, 0);
                add_entry(OP_SBC_IMM, 8'h41, 8'hFF, 8'hFF, 8'h00, 8'hFF, 6'b100100, 0, 0);
                add_entry(OP_SBC_IMM, 8'h7F, 8'h7F, 8'hFF, 8'h00, 8'hFF, 6'b010101, 0, 0);
                add_entry(OP_CLV,     8'h00, 8'h7F, 8'hFF, 8'h00, 8'hFF, 6'b000101, 0, 0);
                add_entry(OP_CMP_IMM, 8'h7F, 8'h7F, 8'hFF, 8'h00, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_CMP_IMM, 8'h80, 8'h7F, 8'hFF, 8'h00, 8'hFF, 6'b100100, 0, 0);
                add_entry(OP_CPX_IMM, 8'hFE, 8'h7F, 8'hFF, 8'h00, 8'hFF, 6'b000101, 0, 0);
                add_entry(OP_CPY_IMM, 8'h01, 8'h7F, 8'hFF, 8'h00, 8'hFF, 6'b100100, 0, 0);
                add_entry(OP_AND_IMM, 8'h0F, 8'h0F, 8'hFF, 8'h00, 8'hFF, 6'b000100, 0, 0);
                add_entry(OP_ORA_IMM, 8'hF0, 8'hFF, 8'hFF, 8'h00, 8'hFF, 6'b100100, 0, 0);
                add_entry(OP_EOR_IMM, 8'hFF, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000110, 0, 0);
                add_entry(OP_LDA_IMM, 8'h81, 8'h81, 8'hFF, 8'h00, 8'hFF, 6'b100100, 0, 0);
                add_entry(OP_ASL_A,   8'h00, 8'h02, 8'hFF, 8'h00, 8'hFF, 6'b000101, 0, 0);
                add_entry(OP_ROR_A,   8'h00, 8'h81, 8'hFF, 8'h00, 8'hFF, 6'b100100, 0, 0);
                add_entry(OP_LSR_A,   8'h00, 8'h40, 8'hFF, 8'h00, 8'hFF, 6'b000101, 0, 0);
                add_entry(OP_ROL_A,   8'h00, 8'h81, 8'hFF, 8'h00, 8'hFF, 6'b100100, 0, 0);
                add_entry(OP_ROL_A,   8'h00, 8'h02, 8'hFF, 8'h00, 8'hFF, 6'b000101, 0, 0);
                add_entry(OP_LSR_A,   8'h00, 8'h01, 8'hFF, 8'h00, 8'hFF, 6'b000100, 0, 0);
                add_entry(OP_LSR_A,   8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_INX,     8'h00, 8'h00, 8'h00, 8'h00, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_DEX,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b100101, 0, 0);
                add_entry(OP_DEY,     8'h00, 8'h00, 8'hFF, 8'hFF, 8'hFF, 6'b100101, 0, 0);
                add_entry(OP_INY,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_CLC,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000110, 0, 0);
                add_entry(OP_SEC,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_CLI,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000011, 0, 0);
                add_entry(OP_SEI,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_SED,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b001111, 0, 0);
                add_entry(OP_CLD,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_NOP,     8'h00, 8'h00, 8'hFF, 8'h00, 8'hFF, 6'b000111, 0, 0);
                add_entry(OP_LDX_IMM, 8'h41, 8'h00, 8'h41, 8'h00, 8'hFF, 6'b000101, 0, 0);
                add_entry(8'hFF,      8'h55, 8'h00, 8'h41, 8'h00, 8'hFF, 6'b000101, 1, 1);
                add_entry(OP_INX,     8'h00, 8'h00, 8'h42, 8'h00, 8'hFF, 6'b000101, 0, 1);
                add_entry(OP_TXA,     8'h00, 8'h42, 8'h42, 8'h00, 8'hFF, 6'b000101, 0, 1);
                add_entry(OP_ADC_IMM, 8'h01, 8'h44, 8'h42, 8'h00, 8'hFF, 6'b000100, 0, 0);
                add_entry(OP_TAY,     8'h00, 8'h44, 8'h42, 8'h44, 8'hFF, 6'b000100, 0, 0);
        endtask

        task automatic check_entry(input int n);
                entry_t e;
                string  tag;
                e   = table_q[n];
                tag = $sformatf("entry %0d", n);
                check_reg(reg_a, e.a, {tag, " A"});
                check_reg(reg_x, e.x, {tag, " X"});
                check_reg(reg_y, e.y, {tag, " Y"});
                check_reg(reg_sp, e.sp, {tag, " SP"});
                check_status(status, e.st, tag);
                check_illegal(illegal, e.ill, tag);
        endtask

        task automatic drive_entry(input int n);
                instr_valid = 1'b1;
                opcode      = opcode_e'(table_q[n].opcode); // Illegal values pass through too
                operand     = table_q[n].operand;
        endtask

        initial begin
                cycle_count = 0;
                forever begin
                        @(posedge clk);
                        cycle_count++;
                        if (cycle_count > 4 * table_q.size() + 20) begin
                                $display("Timeout after %0d cycles, instructions not all retired",
                                         cycle_count - 1);
                                abort_run();
                        end
                end
        end

        initial begin
                error_count = 0;
                reset       = 1'b1;
                instr_valid = 1'b0;
                opcode      = OP_NOP;
                operand     = 8'h00;
                issue_idx   = 0;
                last_chain  = 1'b0;
                build_table();
                repeat (2) @(negedge clk);
                reset = 1'b0;

                check_reg(reg_a, 8'h00, "reset A");
                check_reg(reg_x, 8'h00, "reset X");
                check_reg(reg_y, 8'h00, "reset Y");
                check_reg(reg_sp, 8'hFD, "reset SP");
                check_status(status, status_t'(6'b000100), "reset");
                check_illegal(illegal, 1'b0, "reset");
                if (retire !== 1'b0) begin
                        $display("The retire pulse is high right after reset");
                        abort_run();
                end

                while (issue_idx < table_q.size() || pending.size() != 0) begin
                        @(negedge clk);
                        instr_valid = 1'b0;
                        if (illegal && !retire) begin
                                $display("The illegal output went high without a retire pulse");
                                abort_run();
                        end
                        if (retire) begin
                                if (pending.size() == 0) begin
                                        $display("A retire pulse came with no instruction in flight");
                                        abort_run();
                                end
                                idx = pending.pop_front();
                                check_entry(idx);
                        end
                        if (issue_idx < table_q.size() && (pending.size() == 0 || last_chain)) begin
                                drive_entry(issue_idx);
                                pending.push_back(issue_idx);
                                last_chain = table_q[issue_idx].chain;
                                issue_idx++;
                        end
                end

                if (error_count == 0) begin
                        $display("RESULT: PASS");
                        $finish;
                end else begin
                        abort_run();
                end
        end

endmodule

// ==== rtl/cpu_core.sv ====
module cpu_core import cpu_pkg::*; #(
        parameter byte_t SP_RESET = 8'hFD
) (
        input  logic    clk,
        input  logic    reset,
        input  logic    instr_valid,
        input  opcode_e opcode,
        input  byte_t   operand,
        output byte_t   reg_a,
        output byte_t   reg_x,
        output byte_t   reg_y,
        output byte_t   reg_sp,
        output status_t status,
        output logic    retire,
        output logic    illegal
);

        logic     exec_valid;
        alu_op_e  exec_alu_op;
        src_e     exec_src;
        dest_e    exec_dest;
        flag_op_e exec_flag_op;
        byte_t    exec_operand;
        logic     exec_illegal;
        byte_t    alu_result;
        logic     res_n;
        logic     res_z;
        logic     res_c;
        logic     res_v;

        op_decoder u_decoder (
                .clk          (clk),
                .reset        (reset),
                .instr_valid  (instr_valid),
                .opcode       (opcode),
                .operand      (operand),
                .exec_valid   (exec_valid),
                .exec_alu_op  (exec_alu_op),
                .exec_src     (exec_src),
                .exec_dest    (exec_dest),
                .exec_flag_op (exec_flag_op),
                .exec_operand (exec_operand),
                .exec_illegal (exec_illegal)
        );

        execute_unit u_execute (
                .exec_alu_op  (exec_alu_op),
                .exec_src     (exec_src),
                .exec_operand (exec_operand),
                .reg_a        (reg_a),
                .reg_x        (reg_x),
                .reg_y        (reg_y),
                .reg_sp       (reg_sp),
                .carry_in     (status.c),
                .alu_result   (alu_result),
                .res_n        (res_n),
                .res_z        (res_z),
                .res_c        (res_c),
                .res_v        (res_v)
        );

        result_unit #(
                .SP_RESET (SP_RESET)
        ) u_result (
                .clk          (clk),
                .reset        (reset),
                .exec_valid   (exec_valid),
                .exec_dest    (exec_dest),
                .exec_flag_op (exec_flag_op),
                .exec_illegal (exec_illegal),
                .alu_result   (alu_result),
                .res_n        (res_n),
                .res_z        (res_z),
                .res_c        (res_c),
                .res_v        (res_v),
                .reg_a        (reg_a),
                .reg_x        (reg_x),
                .reg_y        (reg_y),
                .reg_sp       (reg_sp),
                .status       (status),
                .retire       (retire),
                .illegal      (illegal)
        );

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

        typedef logic [7:0] byte_t;

        typedef struct packed {
                logic n;                        // Negative
                logic v;                        // Signed overflow
                logic d;                        // Decimal mode that is only stored
                logic i;                        // IRQ disable
                logic z;                        // Zero
                logic c;                        // Carry
        } status_t;

        typedef enum logic [3:0] {
                ALU_LOAD, ALU_PASS, ALU_ADC, ALU_SBC, ALU_CMP, ALU_AND, ALU_OR,
                ALU_XOR, ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR, ALU_INC, ALU_DEC
        } alu_op_e;

        typedef enum logic [1:0] {SRC_A, SRC_X, SRC_Y, SRC_SP} src_e;

        typedef enum logic [2:0] {
                DEST_NONE, DEST_A, DEST_X, DEST_Y, DEST_SP, DEST_PS
        } dest_e;

        typedef enum logic [3:0] {
                FLG_NONE, FLG_NZ, FLG_NZC, FLG_NZCV, FLG_SET_C, FLG_CLR_C,
                FLG_SET_I, FLG_CLR_I, FLG_SET_D, FLG_CLR_D, FLG_CLR_V
        } flag_op_e;

        typedef enum logic [7:0] {
                OP_LDA_IMM = 8'hA9,
                OP_LDX_IMM = 8'hA2,
                OP_LDY_IMM = 8'hA0,
                OP_ADC_IMM = 8'h69,
                OP_SBC_IMM = 8'hE9,
                OP_AND_IMM = 8'h29,
                OP_ORA_IMM = 8'h09,
                OP_EOR_IMM = 8'h49,
                OP_CMP_IMM = 8'hC9,
                OP_CPX_IMM = 8'hE0,
                OP_CPY_IMM = 8'hC0,
                OP_ASL_A   = 8'h0A,
                OP_LSR_A   = 8'h4A,
                OP_ROL_A   = 8'h2A,
                OP_ROR_A   = 8'h6A,
                OP_INX     = 8'hE8,
                OP_DEX     = 8'hCA,
                OP_INY     = 8'hC8,
                OP_DEY     = 8'h88,
                OP_TAX     = 8'hAA,
                OP_TAY     = 8'hA8,
                OP_TXA     = 8'h8A,
                OP_TYA     = 8'h98,
                OP_TSX     = 8'hBA,
                OP_TXS     = 8'h9A,
                OP_CLC     = 8'h18,
                OP_SEC     = 8'h38,
                OP_CLI     = 8'h58,
                OP_SEI     = 8'h78,
                OP_CLD     = 8'hD8,
                OP_SED     = 8'hF8,
                OP_CLV     = 8'hB8,
                OP_NOP     = 8'hEA
        } opcode_e;

endpackage

// ==== rtl/execute_unit.sv ====
module execute_unit import cpu_pkg::*; (
        input  alu_op_e exec_alu_op,
        input  src_e    exec_src,
        input  byte_t   exec_operand,
        input  byte_t   reg_a,
        input  byte_t   reg_x,
        input  byte_t   reg_y,
        input  byte_t   reg_sp,
        input  logic    carry_in,
        output byte_t   alu_result,
        output logic    res_n,
        output logic    res_z,
        output logic    res_c,
        output logic    res_v
);

        byte_t      src;
        byte_t      addend;
        logic       add_cin;
        logic [8:0] sum;

        always_comb begin
                case (exec_src)
                        SRC_X:   src = reg_x;
                        SRC_Y:   src = reg_y;
                        SRC_SP:  src = reg_sp;
                        default: src = reg_a;
                endcase
        end

        // One adder serves ADC, SBC and compare
        always_comb begin
                addend  = exec_operand;
                add_cin = carry_in;
                if (exec_alu_op == ALU_SBC || exec_alu_op == ALU_CMP) begin
                        addend = ~exec_operand; // Subtract by ones complement
                end
                if (exec_alu_op == ALU_CMP) begin
                        add_cin = 1'b1;         // Compare ignores incoming carry
                end
                sum = {1'b0, src} + {1'b0, addend} + {8'd0, add_cin};
        end

        always_comb begin
                alu_result = src;
                res_c      = carry_in;          // Kept unless the op produces one
                res_v      = 1'b0;
                case (exec_alu_op)
                        ALU_LOAD: alu_result = exec_operand;
                        ALU_PASS: alu_result = src;
                        ALU_ADC, ALU_SBC: begin
                                alu_result = sum[7:0];
                                res_c      = sum[8];
                                res_v      = (src[7] == addend[7]) && (sum[7] != src[7]);
                        end
                        ALU_CMP: begin
                                alu_result = sum[7:0];
                                res_c      = sum[8]; // Set when src >= operand
                        end
                        ALU_AND:  alu_result = src & exec_operand;
                        ALU_OR:   alu_result = src | exec_operand;
                        ALU_XOR:  alu_result = src ^ exec_operand;
                        ALU_ASL: begin
                                alu_result = {src[6:0], 1'b0};
                                res_c      = src[7];
                        end
                        ALU_LSR: begin
                                alu_result = {1'b0, src[7:1]};
                                res_c      = src[0];
                        end
                        ALU_ROL: begin
                                alu_result = {src[6:0], carry_in};
                                res_c      = src[7];
                        end
                        ALU_ROR: begin
                                alu_result = {carry_in, src[7:1]};
                                res_c      = src[0];
                        end
                        ALU_INC:  alu_result = src + 8'd1;
                        ALU_DEC:  alu_result = src - 8'd1;
                        default:  alu_result = src;
                endcase
        end

        assign res_n = alu_result[7];
        assign res_z = (alu_result == 8'd0);

endmodule

// ==== rtl/op_decoder.sv ====
module op_decoder import cpu_pkg::*; (
        input  logic     clk,
        input  logic     reset,
        input  logic     instr_valid,
        input  opcode_e  opcode,
        input  byte_t    operand,
        output logic     exec_valid,
        output alu_op_e  exec_alu_op,
        output src_e     exec_src,
        output dest_e    exec_dest,
        output flag_op_e exec_flag_op,
        output byte_t    exec_operand,
        output logic     exec_illegal
);

        alu_op_e  alu_op;
        src_e     src;
        dest_e    dest;
        flag_op_e flag_op;
        logic     illegal_op;

        // Destination table that also flags unknown opcodes
        always_comb begin
                illegal_op = 1'b0;
                dest       = DEST_NONE;
                case (opcode)
                        OP_LDA_IMM, OP_ADC_IMM, OP_SBC_IMM, OP_AND_IMM, OP_ORA_IMM,
                        OP_EOR_IMM, OP_ASL_A, OP_LSR_A, OP_ROL_A, OP_ROR_A,
                        OP_TXA, OP_TYA:                 dest = DEST_A;
                        OP_LDX_IMM, OP_INX, OP_DEX, OP_TAX, OP_TSX:
                                                        dest = DEST_X;
                        OP_LDY_IMM, OP_INY, OP_DEY, OP_TAY:
                                                        dest = DEST_Y;
                        OP_TXS:                         dest = DEST_SP;
                        OP_CLC, OP_SEC, OP_CLI, OP_SEI, OP_CLD, OP_SED, OP_CLV:
                                                        dest = DEST_PS;
                        OP_CMP_IMM, OP_CPX_IMM, OP_CPY_IMM, OP_NOP:
                                                        dest = DEST_NONE; // Flags only or nothing
                        default:                        illegal_op = 1'b1;
                endcase
        end

        always_comb begin
                case (opcode)
                        OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: alu_op = ALU_LOAD;
                        OP_ADC_IMM:                 alu_op = ALU_ADC;
                        OP_SBC_IMM:                 alu_op = ALU_SBC;
                        OP_CMP_IMM, OP_CPX_IMM, OP_CPY_IMM: alu_op = ALU_CMP;
                        OP_AND_IMM:                 alu_op = ALU_AND;
                        OP_ORA_IMM:                 alu_op = ALU_OR;
                        OP_EOR_IMM:                 alu_op = ALU_XOR;
                        OP_ASL_A:                   alu_op = ALU_ASL;
                        OP_LSR_A:                   alu_op = ALU_LSR;
                        OP_ROL_A:                   alu_op = ALU_ROL;
                        OP_ROR_A:                   alu_op = ALU_ROR;
                        OP_INX, OP_INY:             alu_op = ALU_INC;
                        OP_DEX, OP_DEY:             alu_op = ALU_DEC;
                        default:                    alu_op = ALU_PASS; // Transfers
                endcase
        end

        // Register feeding the ALU is A unless the opcode names another
        always_comb begin
                case (opcode)
                        OP_CPX_IMM, OP_INX, OP_DEX, OP_TXA, OP_TXS: src = SRC_X;
                        OP_CPY_IMM, OP_INY, OP_DEY, OP_TYA:         src = SRC_Y;
                        OP_TSX:                                     src = SRC_SP;
                        default:                                    src = SRC_A;
                endcase
        end

        always_comb begin
                case (opcode)
                        OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_AND_IMM, OP_ORA_IMM,
                        OP_EOR_IMM, OP_INX, OP_DEX, OP_INY, OP_DEY, OP_TAX, OP_TAY,
                        OP_TXA, OP_TYA, OP_TSX:     flag_op = FLG_NZ;
                        OP_CMP_IMM, OP_CPX_IMM, OP_CPY_IMM, OP_ASL_A, OP_LSR_A,
                        OP_ROL_A, OP_ROR_A:         flag_op = FLG_NZC;
                        OP_ADC_IMM, OP_SBC_IMM:     flag_op = FLG_NZCV;
                        OP_SEC:                     flag_op = FLG_SET_C;
                        OP_CLC:                     flag_op = FLG_CLR_C;
                        OP_SEI:                     flag_op = FLG_SET_I;
                        OP_CLI:                     flag_op = FLG_CLR_I;
                        OP_SED:                     flag_op = FLG_SET_D;
                        OP_CLD:                     flag_op = FLG_CLR_D;
                        OP_CLV:                     flag_op = FLG_CLR_V;
                        default:                    flag_op = FLG_NONE; // TXS, NOP, illegal
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        exec_valid   <= 1'b0;
                        exec_illegal <= 1'b0;
                end else begin
                        exec_valid <= instr_valid;
                        if (instr_valid) begin
                                exec_illegal <= illegal_op;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (instr_valid) begin          // Payload held between strobes
                        exec_alu_op  <= alu_op;
                        exec_src     <= src;
                        exec_dest    <= dest;
                        exec_flag_op <= flag_op;
                        exec_operand <= operand;
                end
        end

        // An illegal opcode must reach the result stage with no write or flag effect
        a_illegal_no_effect: assert property (@(posedge clk) disable iff (reset)
                exec_valid && exec_illegal |->
                        exec_dest == DEST_NONE && exec_flag_op == FLG_NONE);

endmodule

// ==== rtl/result_unit.sv ====
module result_unit import cpu_pkg::*; #(
        parameter byte_t SP_RESET = 8'hFD
) (
        input  logic     clk,
        input  logic     reset,
        input  logic     exec_valid,
        input  dest_e    exec_dest,
        input  flag_op_e exec_flag_op,
        input  logic     exec_illegal,
        input  byte_t    alu_result,
        input  logic     res_n,
        input  logic     res_z,
        input  logic     res_c,
        input  logic     res_v,
        output byte_t    reg_a,
        output byte_t    reg_x,
        output byte_t    reg_y,
        output byte_t    reg_sp,
        output status_t  status,
        output logic     retire,
        output logic     illegal
);

        always_ff @(posedge clk) begin
                if (reset) begin
                        reg_a  <= 8'd0;
                        reg_x  <= 8'd0;
                        reg_y  <= 8'd0;
                        reg_sp <= SP_RESET;
                        status <= '{i: 1'b1, default: 1'b0}; // Interrupts masked
                end else if (exec_valid) begin
                        case (exec_dest)
                                DEST_A:  reg_a  <= alu_result;
                                DEST_X:  reg_x  <= alu_result;
                                DEST_Y:  reg_y  <= alu_result;
                                DEST_SP: reg_sp <= alu_result;
                                default: ;      // PS goes through the flag op
                        endcase
                        case (exec_flag_op)
                                FLG_NZ: begin
                                        status.n <= res_n;
                                        status.z <= res_z;
                                end
                                FLG_NZC: begin
                                        status.n <= res_n;
                                        status.z <= res_z;
                                        status.c <= res_c;
                                end
                                FLG_NZCV: begin
                                        status.n <= res_n;
                                        status.z <= res_z;
                                        status.c <= res_c;
                                        status.v <= res_v;
                                end
                                FLG_SET_C: status.c <= 1'b1;
                                FLG_CLR_C: status.c <= 1'b0;
                                FLG_SET_I: status.i <= 1'b1;
                                FLG_CLR_I: status.i <= 1'b0;
                                FLG_SET_D: status.d <= 1'b1;
                                FLG_CLR_D: status.d <= 1'b0;
                                FLG_CLR_V: status.v <= 1'b0;
                                default:   ;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        retire  <= 1'b0;
                        illegal <= 1'b0;
                end else begin
                        retire  <= exec_valid;
                        illegal <= exec_valid && exec_illegal;
                end
        end

        // An illegal retire comes with retire and leaves every register as it was
        a_illegal_retire: assert property (@(posedge clk) disable iff (reset)
                illegal |-> retire && $stable({reg_a, reg_x, reg_y, reg_sp, status}));

endmodule
